/* hw/acp_macros.svh */
// acp sample-memory port: widths, depths, latency and credit constants
`ifndef ACP_MACROS_SVH
`define ACP_MACROS_SVH

// host bus word
`define ACP_BUS_WIDTH     32
// one stereo channel, two per bus word
`define ACP_SAMPLE_WIDTH  16

// sample memory geometry, depth is 2**addr width so addresses wrap for free
`define ACP_ADDR_WIDTH    5
`define ACP_MEM_DEPTH     32

// burst code field of the control word
`define ACP_BURST_WIDTH   3
// beat, latency and queue level counters, holds 0..8
`define ACP_CNT_WIDTH     4

// wait cycles after ack, also ram read pipeline depth
`define ACP_LATENCY       2

// return path sizing
// one max burst fits in the queue
`define ACP_QUEUE_DEPTH   8
// host receive slots after reset
`define ACP_HOST_CREDITS  4

`endif

/* hw/acp_bus_pkg.sv */
// host-side types for the acp request and return ports
package acp_bus_pkg;

`include "acp_macros.svh"

    // control word from host
    typedef struct packed {
        logic                        write;
        logic [`ACP_BURST_WIDTH-1:0] burst;
    } acp_ctrl_t;

    // address phase decode of the bus word
    typedef struct packed {
        logic [`ACP_BUS_WIDTH-`ACP_ADDR_WIDTH-1:0] unused;
        logic [`ACP_ADDR_WIDTH-1:0]                start;
    } acp_addr_view_t;

    // data phase decode, left channel in the upper half
    typedef struct packed {
        logic [`ACP_SAMPLE_WIDTH-1:0] left;
        logic [`ACP_SAMPLE_WIDTH-1:0] right;
    } acp_sample_view_t;

    // same 32 bits, meaning depends on the phase
    typedef union packed {
        acp_addr_view_t   addr;
        acp_sample_view_t sample;
    } acp_bus_word_t;

    // one beat on the return port
    typedef struct packed {
        acp_bus_word_t word;
    } acp_rd_beat_t;

endpackage

/* hw/acp_mem_pkg.sv */
// memory-side types for the acp sequencer and sample ram
package acp_mem_pkg;

    import acp_bus_pkg::*;

`include "acp_macros.svh"

    // one ram request per cycle, 39 bits
    typedef struct packed {
        logic                       we;
        logic                       re;
        logic [`ACP_ADDR_WIDTH-1:0] addr;
        acp_bus_word_t              word;
    } acp_ram_req_t;

    // sequencer states, same order as the request protocol
    typedef enum logic [2:0] {
        ST_WAIT_FOR_ACK = 3'd0,
        ST_WRITE_WAIT   = 3'd1,
        ST_READ_WAIT    = 3'd2,
        ST_WRITE_DATA   = 3'd3,
        ST_READ_DATA    = 3'd4,
        ST_FINISH       = 3'd5
    } acp_seq_state_t;

endpackage

/* hw/acp_mem_interface.sv */
// acp request sequencer: ack/wait handshake, burst decode, latency and beat counting
`timescale 1ns/1ps

`include "acp_macros.svh"

module acp_mem_interface
    import acp_bus_pkg::*;
    import acp_mem_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req_ack,
    input  acp_ctrl_t                 req_ctrl,
    input  acp_bus_word_t             req_word,
    output logic                      req_wait,
    output acp_ram_req_t              ram_req,
    input  logic [`ACP_CNT_WIDTH-1:0] q_free,
    output logic                      q_reserve,
    output logic [`ACP_CNT_WIDTH-1:0] q_reserve_len
);

    localparam int CW = `ACP_CNT_WIDTH;
    localparam int AW = `ACP_ADDR_WIDTH;
    // last value of the latency counter before the data phase
    localparam logic [CW-1:0] LAT_LAST = CW'(`ACP_LATENCY - 1);

    acp_seq_state_t              state_q;
    acp_seq_state_t              state_d;
    logic [CW-1:0]               lat_q;
    logic [CW-1:0]               beat_q;
    logic                        write_q;
    logic [`ACP_BURST_WIDTH-1:0] burst_q;
    logic [AW-1:0]               start_q;
    logic [CW-1:0]               beats;
    logic [CW-1:0]               req_beats;
    logic                        accept;
    logic                        in_wait;
    logic                        in_data;
    logic                        beat_take;
    logic                        last_beat;

    // burst code to beat count, unknown codes move one beat
    function automatic logic [CW-1:0] burst_beats(input logic [`ACP_BURST_WIDTH-1:0] code);
        logic [CW-1:0] n;
        case (code)
            3'd0:    n = CW'(1);
            3'd1:    n = CW'(2);
            3'd2:    n = CW'(4);
            3'd3:    n = CW'(8);
            default: n = CW'(1);
        endcase
        return n;
    endfunction

    // decode both the incoming and the latched code
    assign req_beats = burst_beats(req_ctrl.burst);
    assign beats     = burst_beats(burst_q);

    // reads only go when the whole burst has room in the return queue
    assign accept = (state_q == ST_WAIT_FOR_ACK) && req_ack
                    && (req_ctrl.write || (q_free >= req_beats));

    assign in_wait = (state_q == ST_WRITE_WAIT) || (state_q == ST_READ_WAIT);
    assign in_data = (state_q == ST_WRITE_DATA) || (state_q == ST_READ_DATA);

    // writes need ack per beat, reads stream one request per cycle
    assign beat_take = ((state_q == ST_WRITE_DATA) && req_ack) || (state_q == ST_READ_DATA);
    assign last_beat = beat_take && (beat_q == beats - CW'(1));

    // wait only during the latency phase
    assign req_wait = in_wait;

    // slot reservation on read accept
    assign q_reserve     = accept && !req_ctrl.write;
    assign q_reserve_len = req_beats;

    // ram request, address wraps through the narrow add
    always_comb begin
        ram_req.we   = (state_q == ST_WRITE_DATA) && req_ack;
        ram_req.re   = (state_q == ST_READ_DATA);
        ram_req.addr = start_q + AW'(beat_q);
        ram_req.word = req_word;
    end

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_WAIT_FOR_ACK: begin
                if (accept) begin
                    state_d = req_ctrl.write ? ST_WRITE_WAIT : ST_READ_WAIT;
                end
            end
            ST_WRITE_WAIT: begin
                if (lat_q == LAT_LAST) begin
                    state_d = ST_WRITE_DATA;
                end
            end
            ST_READ_WAIT: begin
                if (lat_q == LAT_LAST) begin
                    state_d = ST_READ_DATA;
                end
            end
            ST_WRITE_DATA, ST_READ_DATA: begin
                if (last_beat) begin
                    state_d = ST_FINISH;
                end
            end
            ST_FINISH: begin
                // hold until host drops ack
                if (!req_ack) begin
                    state_d = ST_WAIT_FOR_ACK;
                end
            end
            default: state_d = ST_WAIT_FOR_ACK;
        endcase
    end

    // state, counters and latched command
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_WAIT_FOR_ACK;
            lat_q   <= '0;
            beat_q  <= '0;
            write_q <= 1'b0;
            burst_q <= '0;
        end else begin
            state_q <= state_d;
            // latency count clears outside the wait states
            lat_q   <= in_wait ? lat_q + CW'(1) : '0;
            // beat index doubles as the address offset
            if (!in_data) begin
                beat_q <= '0;
            end else if (beat_take) begin
                beat_q <= beat_q + CW'(1);
            end
            if (accept) begin
                write_q <= req_ctrl.write;
                burst_q <= req_ctrl.burst;
            end
        end
    end

    // start address from the address view of the bus word
    always_ff @(posedge clk) begin
        if (accept) begin
            start_q <= req_word.addr.start;
        end
    end

    // writes only in the data phase of a latched write command
    a_we_in_write_data: assert property (@(posedge clk) disable iff (rst)
        ram_req.we |-> (state_q == ST_WRITE_DATA) && write_q);

    // a write command never issues ram reads
    a_no_read_on_write: assert property (@(posedge clk) disable iff (rst)
        ram_req.re |-> !write_q && $past(state_q) inside {ST_READ_WAIT, ST_READ_DATA});

endmodule

/* hw/acp_sample_ram.sv */
// acp sample ram: register array, write in request cycle, pipelined read
`timescale 1ns/1ps

`include "acp_macros.svh"

module acp_sample_ram
    import acp_bus_pkg::*;
    import acp_mem_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  acp_ram_req_t  ram_req,
    output logic          ram_rd_valid,
    output acp_bus_word_t ram_rd_word
);

    localparam int LAT = `ACP_LATENCY;

    acp_bus_word_t mem [`ACP_MEM_DEPTH];
    // read pipeline, stage 0 is the array read
    logic          vld_q  [LAT];
    acp_bus_word_t word_q [LAT];

    // array and data stages
    always_ff @(posedge clk) begin
        if (ram_req.we) begin
            mem[ram_req.addr] <= ram_req.word;
        end
        if (ram_req.re) begin
            word_q[0] <= mem[ram_req.addr];
        end
        for (int i = 1; i < LAT; i++) begin
            word_q[i] <= word_q[i-1];
        end
    end

    // valid bits shift alongside, several reads in flight
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < LAT; i++) begin
                vld_q[i] <= 1'b0;
            end
        end else begin
            vld_q[0] <= ram_req.re;
            for (int i = 1; i < LAT; i++) begin
                vld_q[i] <= vld_q[i-1];
            end
        end
    end

    // last stage lands exactly LAT cycles after the request
    assign ram_rd_valid = vld_q[LAT-1];
    assign ram_rd_word  = word_q[LAT-1];

endmodule

/* hw/acp_return_queue.sv */
// acp return queue: read-data fifo with slot reservation and host credit counter
`timescale 1ns/1ps

`include "acp_macros.svh"

module acp_return_queue
    import acp_bus_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      push_valid,
    input  acp_bus_word_t             push_word,
    input  logic                      reserve,
    input  logic [`ACP_CNT_WIDTH-1:0] reserve_len,
    output logic [`ACP_CNT_WIDTH-1:0] free_slots,
    input  logic                      rd_credit,
    output logic                      rd_valid,
    output acp_rd_beat_t              rd_beat
);

    localparam int DEPTH = `ACP_QUEUE_DEPTH;
    localparam int CW    = `ACP_CNT_WIDTH;
    localparam int PW    = $clog2(DEPTH);
    localparam int KW    = $clog2(`ACP_HOST_CREDITS + 1);
    localparam logic [CW-1:0] DEPTH_C   = CW'(DEPTH);
    localparam logic [KW-1:0] CREDITS_C = KW'(`ACP_HOST_CREDITS);

    acp_bus_word_t mem [DEPTH];
    logic [PW-1:0] wr_ptr_q;
    logic [PW-1:0] rd_ptr_q;
    // entries holding data
    logic [CW-1:0] count_q;
    // slots promised to reads still in flight
    logic [CW-1:0] resv_q;
    logic [KW-1:0] credit_q;
    logic          pop;

    // what the sequencer may still claim
    assign free_slots = DEPTH_C - count_q - resv_q;

    // one beat per cycle while data and credit are there
    assign rd_valid     = (count_q != '0) && (credit_q != '0);
    assign rd_beat.word = mem[rd_ptr_q];
    assign pop          = rd_valid;

    // storage
    always_ff @(posedge clk) begin
        if (push_valid) begin
            mem[wr_ptr_q] <= push_word;
        end
    end

    // pointers, levels and credits
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            resv_q   <= '0;
            credit_q <= CREDITS_C;
        end else begin
            if (push_valid) begin
                wr_ptr_q <= wr_ptr_q + PW'(1);
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + PW'(1);
            end
            count_q  <= count_q + CW'(push_valid) - CW'(pop);
            // each arriving beat converts one reservation
            resv_q   <= resv_q + (reserve ? reserve_len : '0) - CW'(push_valid);
            credit_q <= credit_q - KW'(pop) + KW'(rd_credit);
        end
    end

    // every push lands in a reserved slot, so the fifo cannot overflow
    a_push_reserved: assert property (@(posedge clk) disable iff (rst)
        push_valid |-> (resv_q != '0) && (count_q != DEPTH_C));

    // host never returns more credits than it was given
    a_credit_bound: assert property (@(posedge clk) disable iff (rst)
        credit_q <= CREDITS_C);

endmodule

/* hw/acp_mem_top.sv */
// acp sample-memory port top: sequencer, sample ram and return queue
`timescale 1ns/1ps

`include "acp_macros.svh"

module acp_mem_top
    import acp_bus_pkg::*;
    import acp_mem_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          req_ack,
    input  acp_ctrl_t     req_ctrl,
    input  acp_bus_word_t req_word,
    output logic          req_wait,
    output logic          rd_valid,
    output acp_rd_beat_t  rd_beat,
    input  logic          rd_credit
);

    acp_ram_req_t              ram_req;
    logic                      ram_rd_valid;
    acp_bus_word_t             ram_rd_word;
    logic [`ACP_CNT_WIDTH-1:0] q_free;
    logic                      q_reserve;
    logic [`ACP_CNT_WIDTH-1:0] q_reserve_len;

    // command sequencer
    acp_mem_interface u_seq (
        .clk           (clk),
        .rst           (rst),
        .req_ack       (req_ack),
        .req_ctrl      (req_ctrl),
        .req_word      (req_word),
        .req_wait      (req_wait),
        .ram_req       (ram_req),
        .q_free        (q_free),
        .q_reserve     (q_reserve),
        .q_reserve_len (q_reserve_len)
    );

    // sample storage
    acp_sample_ram u_ram (
        .clk          (clk),
        .rst          (rst),
        .ram_req      (ram_req),
        .ram_rd_valid (ram_rd_valid),
        .ram_rd_word  (ram_rd_word)
    );

    // read results back to host
    acp_return_queue u_rq (
        .clk         (clk),
        .rst         (rst),
        .push_valid  (ram_rd_valid),
        .push_word   (ram_rd_word),
        .reserve     (q_reserve),
        .reserve_len (q_reserve_len),
        .free_slots  (q_free),
        .rd_credit   (rd_credit),
        .rd_valid    (rd_valid),
        .rd_beat     (rd_beat)
    );

endmodule

/* test/acp_clk_gen.sv */
// acp testbench clock and reset: 8 ns clock, reset held for 4 rising edges
`timescale 1ns/1ps

module acp_clk_gen #(
    parameter real PERIOD_NS  = 8.0,
    parameter int  RST_CYCLES = 4
) (
    output logic clk,
    output logic rst
);

    // free running clock
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    // reset drops shortly after an edge, like every other input
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

/* test/acp_mem_tb.sv */
// acp sample-memory testbench with host model, shadow memory reference, credit return and checker
`timescale 1ns/1ps

`include "acp_macros.svh"

module acp_mem_tb
    import acp_bus_pkg::*;
    import acp_mem_pkg::*;
();

    localparam int DEPTH   = `ACP_MEM_DEPTH;
    localparam int AW      = `ACP_ADDR_WIDTH;
    localparam int LAT     = `ACP_LATENCY;
    localparam int TIMEOUT = 200;

    logic          clk;
    logic          rst;
    logic          req_ack;
    acp_ctrl_t     req_ctrl;
    acp_bus_word_t req_word;
    logic          req_wait;
    logic          rd_valid;
    acp_rd_beat_t  rd_beat;
    logic          rd_credit;

    // shadow of the sample ram and beats still owed by the DUT
    logic [31:0] shadow [DEPTH];
    logic [31:0] exp_q [$];
    int          err_count;
    int          check_count;
    int          beats_seen;
    // beats taken but not yet paid back with a credit
    int          pending_ret;
    // credits granted and not yet used
    int          avail;
    logic        hold_credits;
    integer      seed;
    integer      credit_seed;

    acp_clk_gen clk_gen0 (
        .clk (clk),
        .rst (rst)
    );

    acp_mem_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .req_ack   (req_ack),
        .req_ctrl  (req_ctrl),
        .req_word  (req_word),
        .req_wait  (req_wait),
        .rd_valid  (rd_valid),
        .rd_beat   (rd_beat),
        .rd_credit (rd_credit)
    );

    // codes 0..3 give 1, 2, 4 or 8 beats and the rest one beat
    function automatic int burst_len(input logic [2:0] code);
        if (code > 3'd3) begin
            return 1;
        end
        return 1 << code;
    endfunction

    // beat address wrapping at the memory depth
    function automatic logic [AW-1:0] wrap_addr(input int start, input int beat);
        return AW'((start + beat) % DEPTH);
    endfunction

    // reference model of a read beat
    function automatic logic [31:0] expected_word(input int start, input int beat);
        return shadow[wrap_addr(start, beat)];
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        err_count++;
        $display("timeout at %0t while waiting for %s", $time, what);
    endtask

    // one full host command from ack through finish and ack drop
    task automatic run_cmd(input logic write, input logic [2:0] code, input int start);
        int          n;
        int          t;
        int          waits;
        int          extra;
        logic [31:0] data;
        n = burst_len(code);
        @(posedge clk);
        #1;
        req_ack        = 1'b1;
        req_ctrl.write = write;
        req_ctrl.burst = code;
        req_word       = '0;
        req_word.addr.start = start[AW-1:0];
        // a read may sit in idle until the queue has room
        t = 0;
        @(posedge clk);
        #1;
        while (!req_wait && t < TIMEOUT) begin
            @(posedge clk);
            #1;
            t++;
        end
        if (!req_wait) begin
            report_timeout("command acceptance");
            req_ack = 1'b0;
            return;
        end
        if (!write) begin
            for (int i = 0; i < n; i++) begin
                exp_q.push_back(expected_word(start, i));
            end
        end
        // latency phase with its first cycle already seen
        waits = 1;
        @(posedge clk);
        #1;
        while (req_wait && waits <= LAT + 2) begin
            waits++;
            @(posedge clk);
            #1;
        end
        check_value("req_wait cycles", waits, LAT);
        // one write beat per cycle with ack held
        if (write) begin
            for (int i = 0; i < n; i++) begin
                if (i > 0) begin
                    @(posedge clk);
                    #1;
                end
                data     = $random(seed);
                req_word = data;
                shadow[wrap_addr(start, i)] = data;
            end
        end
        t = 0;
        while (dut0.u_seq.state_q != ST_FINISH && t < TIMEOUT) begin
            @(posedge clk);
            #1;
            t++;
        end
        if (dut0.u_seq.state_q != ST_FINISH) begin
            report_timeout("burst completion");
            req_ack = 1'b0;
            return;
        end
        // sequencer must stay in finish while ack is held
        extra = 1 + $unsigned($random(seed)) % 2;
        repeat (extra) begin
            @(posedge clk);
            #1;
            check_value("state_q in finish", 32'(dut0.u_seq.state_q), 32'(ST_FINISH));
            check_value("req_wait in finish", 32'(req_wait), 32'd0);
        end
        req_ack = 1'b0;
        @(posedge clk);
        #1;
        check_value("state_q after ack drop", 32'(dut0.u_seq.state_q), 32'(ST_WAIT_FOR_ACK));
    endtask

    // all reads delivered and every credit returned
    task automatic wait_drain();
        int t;
        t = 0;
        while ((exp_q.size() != 0 || pending_ret != 0) && t < TIMEOUT) begin
            @(posedge clk);
            #1;
            t++;
        end
        if (exp_q.size() != 0 || pending_ret != 0) begin
            report_timeout("return port to drain");
        end
    endtask

    // compare each return beat with the oldest expected word
    always @(negedge clk) begin
        if (!rst && rd_valid) begin
            beats_seen++;
            pending_ret++;
            if (avail <= 0) begin
                err_count++;
                $display("return beat at %0t was sent without a host credit", $time);
            end
            avail--;
            if (exp_q.size() == 0) begin
                err_count++;
                $display("return beat at %0t arrived with no read outstanding", $time);
            end else begin
                check_value("rd_beat.word", rd_beat.word, exp_q.pop_front());
            end
        end
    end

    // host receive side frees one slot after a random gap
    initial begin
        int gap;
        gap       = 0;
        rd_credit = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            rd_credit = 1'b0;
            if (gap > 0) begin
                gap--;
            end else if (!hold_credits && pending_ret > 0) begin
                rd_credit = 1'b1;
                pending_ret--;
                avail++;
                gap = $unsigned($random(credit_seed)) % 4;
            end
        end
    end

    initial begin
        int t;
        int base;
        seed         = 18242;
        credit_seed  = 18242;
        err_count    = 0;
        check_count  = 0;
        beats_seen   = 0;
        pending_ret  = 0;
        avail        = `ACP_HOST_CREDITS;
        hold_credits = 1'b0;
        req_ack      = 1'b0;
        req_ctrl     = '0;
        req_word     = '0;
        t = 0;
        while (rst !== 1'b0 && t < TIMEOUT) begin
            @(posedge clk);
            t++;
        end
        if (rst !== 1'b0) begin
            report_timeout("reset release");
        end
        @(posedge clk);
        #1;
        // idle outputs after reset
        check_value("req_wait", 32'(req_wait), 32'd0);
        check_value("rd_valid", 32'(rd_valid), 32'd0);
        check_value("state_q", 32'(dut0.u_seq.state_q), 32'(ST_WAIT_FOR_ACK));
        check_value("free_slots", 32'(dut0.u_rq.free_slots), `ACP_QUEUE_DEPTH);
        // fill the whole memory with max bursts
        for (int a = 0; a < DEPTH; a += 8) begin
            run_cmd(1'b1, 3'd3, a);
        end
        // each valid burst code is written then read back
        run_cmd(1'b1, 3'd0, 3);
        run_cmd(1'b0, 3'd0, 3);
        run_cmd(1'b1, 3'd1, 9);
        run_cmd(1'b0, 3'd1, 9);
        run_cmd(1'b1, 3'd2, 13);
        run_cmd(1'b0, 3'd2, 13);
        run_cmd(1'b1, 3'd3, 20);
        run_cmd(1'b0, 3'd3, 20);
        // codes above 3 touch one word and leave the neighbours alone
        for (int c = 4; c < 8; c++) begin
            run_cmd(1'b1, 3'(c), 11);
            run_cmd(1'b0, 3'd3, 8);
            run_cmd(1'b0, 3'(c), 11);
        end
        // wrap from the top of memory to address 0
        run_cmd(1'b1, 3'd3, 28);
        run_cmd(1'b0, 3'd3, 28);
        run_cmd(1'b0, 3'd2, 0);
        wait_drain();
        // with credits withheld only the reset credits may go out
        hold_credits = 1'b1;
        base = beats_seen;
        run_cmd(1'b0, 3'd3, 16);
        repeat (20) @(posedge clk);
        check_value("beats without credit return", beats_seen - base, `ACP_HOST_CREDITS);
        // next reads must wait in idle until the queue drains
        fork
            begin
                run_cmd(1'b0, 3'd3, 24);
                run_cmd(1'b0, 3'd2, 6);
            end
            begin
                repeat (12) @(posedge clk);
                @(negedge clk);
                check_value("state_q with queue full", 32'(dut0.u_seq.state_q),
                            32'(ST_WAIT_FOR_ACK));
                check_value("req_wait with queue full", 32'(req_wait), 32'd0);
                hold_credits = 1'b0;
            end
        join
        wait_drain();
        check_value("total return beats", beats_seen - base, 20);
        $display("checks: %0d  errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* acp_mem_top.f */
+incdir+hw
hw/acp_bus_pkg.sv
hw/acp_mem_pkg.sv
hw/acp_mem_interface.sv
hw/acp_sample_ram.sv
hw/acp_return_queue.sv
hw/acp_mem_top.sv
test/acp_clk_gen.sv
test/acp_mem_tb.sv

/* Makefile */
# Verilator build and run for the acp sample-memory port

TB_TOP := acp_mem_tb

.PHONY: all lint clean

# build the testbench, run it, and pass only if the pass line shows up
all:
	verilator --binary --timing --assert -f acp_mem_top.f --top-module $(TB_TOP)
	@out="$$(./obj_dir/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

# full warning set on the synthesizable top
lint:
	verilator --lint-only --timing -Wall -f acp_mem_top.f --top-module acp_mem_top

clean:
	rm -rf obj_dir
